/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = board_io_tb
FILELIST  = src.f
SIM_ARGS  = +verilator+error+limit+100
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) $(SIM_ARGS) | tee $(LOG)
	grep -qx "TEST OK" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* design/board_io_top.sv */
// *******************************************************************
// Board I/O layer top. Connects reset release, host registers, the
// two pin banks and the shared I2C splitter; the board wrapper turns
// every value/enable pair into a pad
// *******************************************************************
`timescale 1ns/1ps

module board_io_top
  import board_pkg::*;
#(
  parameter int unsigned NumI2cConn    = 3,
  parameter int unsigned RstHoldCycles = 16
) (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic                  pll_locked_i,
  input  logic                  rst_btn_i,

  // Host port
  input  logic                  req_i,
  input  logic                  we_i,
  input  logic [AddrWidth-1:0]  addr_i,
  input  logic [DataWidth-1:0]  wdata_i,
  output logic                  ack_o,
  output logic [DataWidth-1:0]  rdata_o,

  input  logic [GpioWidth-1:0]  bank0_pin_i,
  output logic [GpioWidth-1:0]  bank0_pin_o,
  output logic [GpioWidth-1:0]  bank0_pin_oe_o,
  input  logic [GpioWidth-1:0]  bank1_pin_i,
  output logic [GpioWidth-1:0]  bank1_pin_o,
  output logic [GpioWidth-1:0]  bank1_pin_oe_o,

  input  logic [SwWidth-1:0]    sw_i,
  output logic [LedWidth-1:0]   led_o,

  input  logic [NumI2cConn-1:0] scl_i,
  input  logic [NumI2cConn-1:0] sda_i,
  output logic [NumI2cConn-1:0] scl_en_o,
  output logic [NumI2cConn-1:0] sda_en_o,

  output logic                  boot_ok_o
);

  logic                  sys_rst;
  logic [1:0]            bank_wr;
  reg_word_u             bank_ctl;
  reg_word_u             bank0_ctl;
  reg_word_u             bank1_ctl;
  logic [GpioWidth-1:0]  bank0_sync;
  logic [GpioWidth-1:0]  bank1_sync;
  logic [NumI2cConn-1:0] i2c_mask;
  logic                  scl_low;
  logic                  sda_low;
  logic                  scl_sync;
  logic                  sda_sync;

  assign boot_ok_o = ~sys_rst;  // Boot LED

  rst_ctrl #(
    .RstHoldCycles(RstHoldCycles)
  ) u_rst_ctrl (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .pll_locked_i(pll_locked_i),
    .rst_btn_i   (rst_btn_i),
    .sys_rst_o   (sys_rst)
  );

  host_regs #(
    .NumI2cConn(NumI2cConn)
  ) u_host_regs (
    .clk_i      (clk_i),
    .reset_i    (sys_rst),
    .req_i      (req_i),
    .we_i       (we_i),
    .addr_i     (addr_i),
    .wdata_i    (wdata_i),
    .ack_o      (ack_o),
    .rdata_o    (rdata_o),
    .bank_wr_o  (bank_wr),
    .bank_ctl_o (bank_ctl),
    .bank0_ctl_i(bank0_ctl),
    .bank1_ctl_i(bank1_ctl),
    .bank0_in_i (bank0_sync),
    .bank1_in_i (bank1_sync),
    .sw_i       (sw_i),
    .led_o      (led_o),
    .i2c_mask_o (i2c_mask),
    .scl_low_o  (scl_low),
    .sda_low_o  (sda_low),
    .scl_in_i   (scl_sync),
    .sda_in_i   (sda_sync)
  );

  gpio_bank u_bank0 (
    .clk_i     (clk_i),
    .reset_i   (sys_rst),
    .wr_i      (bank_wr[0]),
    .ctl_i     (bank_ctl),
    .ctl_o     (bank0_ctl),
    .pin_i     (bank0_pin_i),
    .pin_o     (bank0_pin_o),
    .pin_oe_o  (bank0_pin_oe_o),
    .pin_sync_o(bank0_sync)
  );

  gpio_bank u_bank1 (
    .clk_i     (clk_i),
    .reset_i   (sys_rst),
    .wr_i      (bank_wr[1]),
    .ctl_i     (bank_ctl),
    .ctl_o     (bank1_ctl),
    .pin_i     (bank1_pin_i),
    .pin_o     (bank1_pin_o),
    .pin_oe_o  (bank1_pin_oe_o),
    .pin_sync_o(bank1_sync)
  );

  // Shared bus across the header connectors
  i2c_splitter #(
    .NumI2cConn(NumI2cConn)
  ) u_i2c (
    .clk_i      (clk_i),
    .reset_i    (sys_rst),
    .conn_mask_i(i2c_mask),
    .scl_low_i  (scl_low),
    .sda_low_i  (sda_low),
    .scl_i      (scl_i),
    .sda_i      (sda_i),
    .scl_en_o   (scl_en_o),
    .sda_en_o   (sda_en_o),
    .scl_sync_o (scl_sync),
    .sda_sync_o (sda_sync)
  );

endmodule

/* design/board_pkg.sv */
// *******************************************************************
// Shared constants and types for the board I/O layer: widths, the
// host register map and the two-view register word
// Import into any module that decodes registers or pins
// *******************************************************************
package board_pkg;

  localparam int unsigned GpioWidth = 16;  // Pins per bank
  localparam int unsigned LedWidth  = 8;
  localparam int unsigned SwWidth   = 8;
  localparam int unsigned AddrWidth = 3;
  localparam int unsigned DataWidth = 32;

  // Register map
  localparam logic [AddrWidth-1:0] RegBank0Ctl = 3'd0;  // R/W
  localparam logic [AddrWidth-1:0] RegBank1Ctl = 3'd1;  // R/W
  localparam logic [AddrWidth-1:0] RegLed      = 3'd2;  // R/W
  localparam logic [AddrWidth-1:0] RegBank0In  = 3'd3;  // RO
  localparam logic [AddrWidth-1:0] RegBank1In  = 3'd4;  // RO
  localparam logic [AddrWidth-1:0] RegSwitch   = 3'd5;  // RO
  localparam logic [AddrWidth-1:0] RegI2cCtl   = 3'd6;  // R/W
  localparam logic [AddrWidth-1:0] RegI2cIn    = 3'd7;  // RO

  // I2C control word, mask sits in the low bits
  localparam int unsigned I2cMaskLsb   = 0;
  localparam int unsigned I2cSclLowBit = 8;
  localparam int unsigned I2cSdaLowBit = 9;
  // I2C input word
  localparam int unsigned I2cSclInBit  = 0;
  localparam int unsigned I2cSdaInBit  = 1;

  // Lane indices into the union views
  localparam int unsigned CtlOe   = 1;  // Upper half
  localparam int unsigned CtlOut  = 0;  // Lower half
  localparam int unsigned LedLane = 0;  // Low byte, upper lanes unused

  // One register word, read as pin-bank control or as LED value
  typedef union packed {
    logic [1:0][GpioWidth-1:0]                   ctl;
    logic [DataWidth/LedWidth-1:0][LedWidth-1:0] led;
  } reg_word_u;

endpackage

/* design/gpio_bank.sv */
// *******************************************************************
// One general-purpose pin bank. A write strobe loads the output value
// and enable from the control word, pin inputs are synchronised
// Pads are built outside, each pin leaves as value plus enable
// *******************************************************************
`timescale 1ns/1ps

module gpio_bank
  import board_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 reset_i,

  input  logic                 wr_i,   // One-cycle write strobe
  input  reg_word_u            ctl_i,
  output reg_word_u            ctl_o,  // Read-back of the stored word

  input  logic [GpioWidth-1:0] pin_i,
  output logic [GpioWidth-1:0] pin_o,
  output logic [GpioWidth-1:0] pin_oe_o,
  output logic [GpioWidth-1:0] pin_sync_o
);

  reg_word_u            ctl_q;
  logic [GpioWidth-1:0] pin_meta_q;
  logic [GpioWidth-1:0] pin_sync_q;

  // Control word, all pins released after reset
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ctl_q <= '0;
    end else if (wr_i) begin
      ctl_q <= ctl_i;
    end
  end

  assign pin_o    = ctl_q.ctl[CtlOut];
  assign pin_oe_o = ctl_q.ctl[CtlOe];
  assign ctl_o    = ctl_q;

  // Two-flop synchroniser on the pad inputs
  always_ff @(posedge clk_i) begin
    pin_meta_q <= pin_i;
    pin_sync_q <= pin_meta_q;
  end

  assign pin_sync_o = pin_sync_q;

endmodule

/* design/host_regs.sv */
// *******************************************************************
// Host register block on a four-phase req/ack port. Latches the
// request, performs the access one edge later and holds ack until the
// host drops req. Owns the LED and I2C control registers
// *******************************************************************
`timescale 1ns/1ps

module host_regs
  import board_pkg::*;
#(
  parameter int unsigned NumI2cConn = 3
) (
  input  logic                  clk_i,
  input  logic                  reset_i,

  input  logic                  req_i,
  input  logic                  we_i,
  input  logic [AddrWidth-1:0]  addr_i,
  input  logic [DataWidth-1:0]  wdata_i,
  output logic                  ack_o,
  output logic [DataWidth-1:0]  rdata_o,

  output logic [1:0]            bank_wr_o,
  output reg_word_u             bank_ctl_o,
  input  reg_word_u             bank0_ctl_i,
  input  reg_word_u             bank1_ctl_i,
  input  logic [GpioWidth-1:0]  bank0_in_i,
  input  logic [GpioWidth-1:0]  bank1_in_i,

  input  logic [SwWidth-1:0]    sw_i,
  output logic [LedWidth-1:0]   led_o,

  output logic [NumI2cConn-1:0] i2c_mask_o,
  output logic                  scl_low_o,
  output logic                  sda_low_o,
  input  logic                  scl_in_i,
  input  logic                  sda_in_i
);

  localparam logic [1:0] StIdle   = 2'd0;
  localparam logic [1:0] StAccess = 2'd1;
  localparam logic [1:0] StAck    = 2'd2;

  logic [1:0]            state_q;
  logic [AddrWidth-1:0]  addr_q;
  logic                  we_q;
  reg_word_u             wdata_q;
  logic [DataWidth-1:0]  rdata_q;
  logic [DataWidth-1:0]  rdata_d;
  reg_word_u             led_word;
  logic                  wr_en;
  logic [LedWidth-1:0]   led_q;
  logic [NumI2cConn-1:0] i2c_mask_q;
  logic                  scl_low_q;
  logic                  sda_low_q;
  logic [SwWidth-1:0]    sw_meta_q;
  logic [SwWidth-1:0]    sw_sync_q;

  assign wr_en = (state_q == StAccess) && we_q;

  // Handshake FSM
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= StIdle;
    end else begin
      case (state_q)
        StIdle:   if (req_i) state_q <= StAccess;
        StAccess: state_q <= StAck;
        StAck:    if (!req_i) state_q <= StIdle;  // Drop ack once req seen low
        default:  state_q <= StIdle;
      endcase
    end
  end

  // Request capture and read data
  always_ff @(posedge clk_i) begin
    if (state_q == StIdle && req_i) begin
      addr_q  <= addr_i;
      we_q    <= we_i;
      wdata_q <= wdata_i;
    end
    if (state_q == StAccess) rdata_q <= rdata_d;
  end

  // Local registers update with the bank strobe edge
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      led_q      <= '0;
      i2c_mask_q <= '0;
      scl_low_q  <= 1'b0;
      sda_low_q  <= 1'b0;
    end else if (wr_en) begin
      if (addr_q == RegLed) led_q <= wdata_q.led[LedLane];
      if (addr_q == RegI2cCtl) begin
        i2c_mask_q <= wdata_q[I2cMaskLsb +: NumI2cConn];
        scl_low_q  <= wdata_q[I2cSclLowBit];
        sda_low_q  <= wdata_q[I2cSdaLowBit];
      end
    end
  end

  // Switches pull low when on
  always_ff @(posedge clk_i) begin
    sw_meta_q <= sw_i;
    sw_sync_q <= sw_meta_q;
  end

  always_comb begin
    led_word              = '0;
    led_word.led[LedLane] = led_q;
    rdata_d               = '0;
    case (addr_q)
      RegBank0Ctl: rdata_d = bank0_ctl_i;
      RegBank1Ctl: rdata_d = bank1_ctl_i;
      RegLed:      rdata_d = led_word;
      RegBank0In:  rdata_d[GpioWidth-1:0] = bank0_in_i;
      RegBank1In:  rdata_d[GpioWidth-1:0] = bank1_in_i;
      RegSwitch:   rdata_d[SwWidth-1:0] = ~sw_sync_q;  // 1 means on
      RegI2cCtl: begin
        rdata_d[I2cMaskLsb +: NumI2cConn] = i2c_mask_q;
        rdata_d[I2cSclLowBit]             = scl_low_q;
        rdata_d[I2cSdaLowBit]             = sda_low_q;
      end
      RegI2cIn: begin
        rdata_d[I2cSclInBit] = scl_in_i;
        rdata_d[I2cSdaInBit] = sda_in_i;
      end
      default: rdata_d = '0;
    endcase
  end

  assign bank_wr_o[0] = wr_en && (addr_q == RegBank0Ctl);
  assign bank_wr_o[1] = wr_en && (addr_q == RegBank1Ctl);
  assign bank_ctl_o   = wdata_q;

  assign ack_o      = (state_q == StAck);
  assign rdata_o    = rdata_q;
  assign led_o      = led_q;
  assign i2c_mask_o = i2c_mask_q;
  assign scl_low_o  = scl_low_q;
  assign sda_low_o  = sda_low_q;

endmodule

/* design/i2c_splitter.sv */
// *******************************************************************
// Shares one bit-banged I2C bus across several header connectors.
// The mask picks the connectors in use; lines are open drain, so only
// an enable per connector leaves the block
// *******************************************************************
`timescale 1ns/1ps

module i2c_splitter #(
  parameter int unsigned NumI2cConn = 3
) (
  input  logic                  clk_i,
  input  logic                  reset_i,

  input  logic [NumI2cConn-1:0] conn_mask_i,
  input  logic                  scl_low_i,
  input  logic                  sda_low_i,

  input  logic [NumI2cConn-1:0] scl_i,
  input  logic [NumI2cConn-1:0] sda_i,
  output logic [NumI2cConn-1:0] scl_en_o,  // Pull low when set
  output logic [NumI2cConn-1:0] sda_en_o,

  output logic                  scl_sync_o,
  output logic                  sda_sync_o
);

  logic       scl_merged;
  logic       sda_merged;
  logic [1:0] scl_sync_q;
  logic [1:0] sda_sync_q;

  assign scl_en_o = conn_mask_i & {NumI2cConn{scl_low_i}};
  assign sda_en_o = conn_mask_i & {NumI2cConn{sda_low_i}};

  // Wired AND of the selected connectors, unused ones read high
  assign scl_merged = &(scl_i | ~conn_mask_i);
  assign sda_merged = &(sda_i | ~conn_mask_i);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      scl_sync_q <= 2'b11;  // Idle bus level
      sda_sync_q <= 2'b11;
    end else begin
      scl_sync_q <= {scl_sync_q[0], scl_merged};
      sda_sync_q <= {sda_sync_q[0], sda_merged};
    end
  end

  assign scl_sync_o = scl_sync_q[1];
  assign sda_sync_o = sda_sync_q[1];

endmodule

/* design/rst_ctrl.sv */
// *******************************************************************
// System reset generator. Keeps the system in reset while the clock
// is unlocked or a reset source is active, then releases it after a
// fixed hold count
// *******************************************************************
`timescale 1ns/1ps

module rst_ctrl #(
  parameter int unsigned RstHoldCycles = 16
) (
  input  logic clk_i,
  input  logic reset_i,
  input  logic pll_locked_i,
  input  logic rst_btn_i,
  output logic sys_rst_o
);

  localparam int unsigned CntWidth = $clog2(RstHoldCycles) + 1;
  localparam logic [CntWidth-1:0] CntLast = CntWidth'(RstHoldCycles - 1);

  logic                any_rst;
  logic [CntWidth-1:0] hold_cnt_q;
  logic                sys_rst_q;

  // Any source restarts the hold count
  assign any_rst = reset_i | rst_btn_i | ~pll_locked_i;

  always_ff @(posedge clk_i) begin
    if (any_rst) begin
      hold_cnt_q <= '0;
      sys_rst_q  <= 1'b1;
    end else if (sys_rst_q) begin
      if (hold_cnt_q == CntLast) begin
        sys_rst_q <= 1'b0;  // Release on the last hold edge
      end else begin
        hold_cnt_q <= hold_cnt_q + 1'b1;
      end
    end
  end

  assign sys_rst_o = sys_rst_q;

endmodule

/* src.f */
design/board_pkg.sv
design/rst_ctrl.sv
design/gpio_bank.sv
design/i2c_splitter.sv
design/host_regs.sv
design/board_io_top.sv
tests/board_io_chk.sv
tests/board_io_tb.sv

/* tests/board_io_chk.sv */
// *******************************************************************
// Checks bound into the host register block. They cover the
// four-phase handshake timing and the register state held in reset
// *******************************************************************
`timescale 1ns/1ps

module board_io_chk
  import board_pkg::*;
(
  input logic                 clk_i,
  input logic                 reset_i,
  input logic                 req_i,
  input logic                 ack_o,
  input logic [DataWidth-1:0] rdata_o,
  input logic [LedWidth-1:0]  led_o,
  input logic                 scl_low_o,
  input logic                 sda_low_o,
  input reg_word_u            bank0_ctl_i,
  input reg_word_u            bank1_ctl_i
);

  int fail_cnt = 0;  // Summed into the closing count

  // One edge after a reset edge, nothing is acked, driven or lit
  reset_state: assert property (@(posedge clk_i)
    reset_i |=> !ack_o && led_o == '0 && !scl_low_o && !sda_low_o &&
                bank0_ctl_i.ctl[CtlOe] == '0 && bank1_ctl_i.ctl[CtlOe] == '0)
    else begin
      fail_cnt++;
      $error("Outputs or enables not cleared while in reset");
    end

  ack_needs_req: assert property (@(posedge clk_i) disable iff (reset_i)
    $rose(ack_o) |-> req_i)
    else begin
      fail_cnt++;
      $error("ack_o rose while req_i was low");
    end

  // Second edge after the first high sample of req
  ack_latency: assert property (@(posedge clk_i) disable iff (reset_i)
    $rose(ack_o) |-> $past(req_i, 1) && $past(req_i, 2) && !$past(req_i, 3))
    else begin
      fail_cnt++;
      $error("ack_o did not rise on the second edge after req_i");
    end

  ack_holds: assert property (@(posedge clk_i) disable iff (reset_i)
    ack_o && req_i |=> ack_o)
    else begin
      fail_cnt++;
      $error("ack_o fell while req_i was still high");
    end

  ack_drops: assert property (@(posedge clk_i) disable iff (reset_i)
    ack_o && !req_i |=> !ack_o)
    else begin
      fail_cnt++;
      $error("ack_o stayed high after req_i fell");
    end

  rdata_held: assert property (@(posedge clk_i) disable iff (reset_i)
    ack_o && req_i |=> $stable(rdata_o))
    else begin
      fail_cnt++;
      $error("rdata_o changed while ack_o was held");
    end

endmodule

bind host_regs board_io_chk u_chk (
  .clk_i      (clk_i),
  .reset_i    (reset_i),
  .req_i      (req_i),
  .ack_o      (ack_o),
  .rdata_o    (rdata_o),
  .led_o      (led_o),
  .scl_low_o  (scl_low_o),
  .sda_low_o  (sda_low_o),
  .bank0_ctl_i(bank0_ctl_i),
  .bank1_ctl_i(bank1_ctl_i)
);

/* tests/board_io_tb.sv */
// *******************************************************************
// Testbench for the board I/O layer. Boots the DUT, runs host
// accesses with LFSR stimulus and compares pins and read data with a
// model of the register map
// *******************************************************************
`timescale 1ns/1ps

module board_io_tb
  import board_pkg::*;
();

  localparam int NumConn     = 3;
  localparam int HoldCycles  = 16;
  localparam int NumTrans    = 64;
  localparam int ResetCycles = 13 + 2 * (HoldCycles + 4);
  localparam int TimeoutNs   = 8 * (200 * NumTrans + ResetCycles);

  logic                 clk_i          = 1'b0;
  logic                 reset_i        = 1'b1;
  logic                 pll_locked_i   = 1'b0;
  logic                 rst_btn_i      = 1'b0;
  logic                 req_i          = 1'b0;
  logic                 we_i           = 1'b0;
  logic [AddrWidth-1:0] addr_i         = '0;
  logic [DataWidth-1:0] wdata_i        = '0;
  logic                 ack_o;
  logic [DataWidth-1:0] rdata_o;
  logic [GpioWidth-1:0] bank0_pin_i    = '0;
  logic [GpioWidth-1:0] bank0_pin_o;
  logic [GpioWidth-1:0] bank0_pin_oe_o;
  logic [GpioWidth-1:0] bank1_pin_i    = '0;
  logic [GpioWidth-1:0] bank1_pin_o;
  logic [GpioWidth-1:0] bank1_pin_oe_o;
  logic [SwWidth-1:0]   sw_i           = '1;  // All switches off
  logic [LedWidth-1:0]  led_o;
  logic [NumConn-1:0]   scl_i          = '1;  // Idle bus
  logic [NumConn-1:0]   sda_i          = '1;
  logic [NumConn-1:0]   scl_en_o;
  logic [NumConn-1:0]   sda_en_o;
  logic                 boot_ok_o;

  int          errors = 0;
  logic [15:0] lfsr   = 16'd76;
  logic [31:0] exp_bank0;  // Register map model
  logic [31:0] exp_bank1;
  logic [31:0] exp_i2c;
  logic [7:0]  exp_led;

  board_io_top #(
    .NumI2cConn   (NumConn),
    .RstHoldCycles(HoldCycles)
  ) uut (.*);

  always #4 clk_i = ~clk_i;

  // Fibonacci LFSR x^16+x^14+x^13+x^11+1 stepped once per bit
  function automatic logic [31:0] rand_bits(int n);
    logic [31:0] val;
    logic        fb;
    val = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
      lfsr = {lfsr[14:0], fb};
      val  = {val[30:0], fb};
    end
    return val;
  endfunction

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    assert (got === exp) else begin
      errors++;
      $display("Error at %0t: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
    end
  endtask

  task automatic host_access(input logic we, input logic [AddrWidth-1:0] addr,
                             input logic [31:0] wdata, output logic [31:0] rdata);
    @(posedge clk_i);
    req_i   <= 1'b1;
    we_i    <= we;
    addr_i  <= addr;
    wdata_i <= wdata;
    do @(negedge clk_i); while (!ack_o);
    rdata = rdata_o;
    @(posedge clk_i);
    req_i <= 1'b0;
    do @(negedge clk_i); while (ack_o);  // Back in idle
  endtask

  task automatic write_reg(input logic [AddrWidth-1:0] addr, input logic [31:0] data);
    logic [31:0] unused;
    host_access(1'b1, addr, data, unused);
  endtask

  task automatic read_expect(input logic [AddrWidth-1:0] addr, input logic [31:0] exp);
    logic [31:0] got;
    host_access(1'b0, addr, 32'h0, got);
    compare_value($sformatf("rdata_o (addr %0d)", addr), got, exp);
  endtask

  // Called on the edge where the last reset source is released
  task automatic expect_boot_release();
    repeat (HoldCycles - 1) @(posedge clk_i);
    @(negedge clk_i);
    compare_value("boot_ok_o", 32'(boot_ok_o), 32'h0);
    @(posedge clk_i);
    @(negedge clk_i);
    compare_value("boot_ok_o", 32'(boot_ok_o), 32'h1);
  endtask

  task automatic bank_writes();
    repeat (4) begin
      exp_bank0 = rand_bits(32);
      exp_bank1 = rand_bits(32);
      write_reg(RegBank0Ctl, exp_bank0);
      write_reg(RegBank1Ctl, exp_bank1);
      compare_value("bank0_pin_o", 32'(bank0_pin_o), {16'h0, exp_bank0[15:0]});
      compare_value("bank0_pin_oe_o", 32'(bank0_pin_oe_o), {16'h0, exp_bank0[31:16]});
      compare_value("bank1_pin_o", 32'(bank1_pin_o), {16'h0, exp_bank1[15:0]});
      compare_value("bank1_pin_oe_o", 32'(bank1_pin_oe_o), {16'h0, exp_bank1[31:16]});
      read_expect(RegBank0Ctl, exp_bank0);
      read_expect(RegBank1Ctl, exp_bank1);
    end
  endtask

  task automatic input_readback();
    repeat (3) begin
      @(posedge clk_i);
      bank0_pin_i <= 16'(rand_bits(16));
      bank1_pin_i <= 16'(rand_bits(16));
      sw_i        <= 8'(rand_bits(8));
      repeat (3) @(posedge clk_i);  // Two-flop synchroniser
      read_expect(RegBank0In, {16'h0, bank0_pin_i});
      read_expect(RegBank1In, {16'h0, bank1_pin_i});
      read_expect(RegSwitch, {24'h0, ~sw_i});  // Switches read 1 when on
    end
  endtask

  task automatic i2c_sharing();
    logic [NumConn-1:0] mask;
    logic               scl_low;
    logic               sda_low;
    logic               scl_exp;
    logic               sda_exp;
    for (int n = 0; n < 6; n++) begin
      mask    = (n == 0) ? '0 : NumConn'(rand_bits(NumConn));  // First pass empty
      scl_low = 1'(rand_bits(1));
      sda_low = 1'(rand_bits(1));
      exp_i2c = 32'(mask);
      exp_i2c[I2cSclLowBit] = scl_low;
      exp_i2c[I2cSdaLowBit] = sda_low;
      @(posedge clk_i);
      scl_i <= NumConn'(rand_bits(NumConn));
      sda_i <= NumConn'(rand_bits(NumConn));
      write_reg(RegI2cCtl, exp_i2c);
      compare_value("scl_en_o", 32'(scl_en_o), scl_low ? 32'(mask) : 32'h0);
      compare_value("sda_en_o", 32'(sda_en_o), sda_low ? 32'(mask) : 32'h0);
      read_expect(RegI2cCtl, exp_i2c);
      scl_exp = 1'b1;
      sda_exp = 1'b1;
      for (int c = 0; c < NumConn; c++) begin
        if (mask[c]) begin
          scl_exp = scl_exp & scl_i[c];
          sda_exp = sda_exp & sda_i[c];
        end
      end
      read_expect(RegI2cIn, {30'h0, sda_exp, scl_exp});
    end
  endtask

  task automatic led_and_map();
    repeat (3) begin
      exp_led = 8'(rand_bits(8));
      write_reg(RegLed, {24'(rand_bits(24)), exp_led});
      compare_value("led_o", 32'(led_o), 32'(exp_led));
      read_expect(RegLed, 32'(exp_led));  // Upper lanes read zero
    end
    // Read-only addresses ignore writes
    write_reg(RegBank0In, rand_bits(32));
    write_reg(RegBank1In, rand_bits(32));
    write_reg(RegSwitch, rand_bits(32));
    write_reg(RegI2cIn, rand_bits(32));
    compare_value("led_o", 32'(led_o), 32'(exp_led));
    read_expect(RegLed, 32'(exp_led));
    read_expect(RegBank0Ctl, exp_bank0);
    read_expect(RegBank1Ctl, exp_bank1);
    read_expect(RegI2cCtl, exp_i2c);
    read_expect(RegBank0In, {16'h0, bank0_pin_i});
    read_expect(RegSwitch, {24'h0, ~sw_i});
  endtask

  initial begin
    int chk_fails;
    repeat (10) @(posedge clk_i);
    reset_i <= 1'b0;
    repeat (3) @(posedge clk_i);
    pll_locked_i <= 1'b1;
    expect_boot_release();
    bank_writes();
    input_readback();
    i2c_sharing();
    led_and_map();
    // Button press drops boot_ok and restarts the hold count
    @(posedge clk_i);
    rst_btn_i <= 1'b1;
    @(posedge clk_i);
    @(negedge clk_i);
    compare_value("boot_ok_o", 32'(boot_ok_o), 32'h0);
    @(posedge clk_i);
    rst_btn_i <= 1'b0;
    expect_boot_release();
    compare_value("led_o", 32'(led_o), 32'h0);
    compare_value("bank0_pin_oe_o", 32'(bank0_pin_oe_o), 32'h0);
    compare_value("bank1_pin_oe_o", 32'(bank1_pin_oe_o), 32'h0);
    chk_fails = uut.u_host_regs.u_chk.fail_cnt;
    $display("Summary: %0d value errors, %0d assertion failures", errors, chk_fails);
    if (errors == 0 && chk_fails == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  initial begin
    #(TimeoutNs);
    $display("Watchdog expired at %0t, the host handshake or boot never completed", $time);
    $display("TEST FAILED");
    $finish;
  end

endmodule
